// File: hw/pmod_mux.sv
`timescale 1ns/1ps

module pmod_mux import skyking_pkg::*; (
	input  pin_mode_t     mode,
	input  vga_pixel_t    pixel,
	input  scope_sample_t sample,
	output logic [7:0]    uo_out,
	output logic [7:0]    uio_out
);

	logic [7:0] vga_pins;
	logic [7:0] xy1_pins;
	logic [7:0] xy2_y_pins;
	logic [7:0] xy2_x_pins;

	// Tiny VGA PMOD pinout
	assign vga_pins = {pixel.hsync, pixel.b[0], pixel.g[0], pixel.r[0],
		pixel.vsync, pixel.b[1], pixel.g[1], pixel.r[1]};

	// Upper bits only, for a single 8-pin resistor DAC board
	assign xy1_pins = {sample.x[4], sample.x[6], sample.y[4], sample.y[6],
		sample.x[5], sample.x[7], sample.y[5], sample.trig};

	assign xy2_y_pins = {sample.trig, sample.y[5], sample.y[3], sample.y[1],
		sample.y[6], sample.y[4], sample.y[2], sample.y[0]};
	assign xy2_x_pins = {sample.x[7], sample.x[5], sample.x[3], sample.x[1],
		sample.x[6], sample.x[4], sample.x[2], sample.x[0]};

	always_comb begin
		case (mode)
			MODE_XY1: begin
				uo_out  = xy1_pins;
				uio_out = 8'h00;
			end
			MODE_VGA_X: begin
				uo_out  = vga_pins;
				uio_out = xy2_x_pins;
			end
			MODE_XY2: begin
				uo_out  = xy2_y_pins;
				uio_out = xy2_x_pins;
			end
			default: begin
				uo_out  = vga_pins;
				uio_out = 8'h00;
			end
		endcase
	end

endmodule

// File: hw/scope_wave.sv
`timescale 1ns/1ps

module scope_wave import skyking_pkg::*; (
	input  logic          clk,
	input  logic          rst_n,
	output scope_sample_t sample
);

	`include "scope_wave.svh"

	logic [PHASE_W-1:0] phase;

	// Wraps on its own since the table depth is a power of two
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			phase  <= '0;
			sample <= '0;
		end else begin
			phase       <= phase + 1'b1;
			sample.x    <= WAVE_X[phase];
			sample.y    <= WAVE_Y[phase];
			sample.trig <= phase[TRIG_BIT];
		end
	end

	a_y_peak: assert property (@(posedge clk) disable iff (!rst_n)
		sample.y <= Y_W'(Y_MAX));

endmodule

// File: hw/sky_scene.sv
`timescale 1ns/1ps

module sky_scene import skyking_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  raster_t    raster,
	input  logic       msg_sel,
	output vga_pixel_t pixel
);

	`include "skyking_glyphs.svh"

	logic [LETTER_DIV_W-1:0] letter_div;
	logic [CURSOR_DIV_W-1:0] blink_div;
	logic [REVEAL_W-1:0]     reveal_cnt;
	logic                    cursor_on;
	logic [LETTER_COUNT-1:0] prim_hit;
	logic [LETTER_COUNT-1:0] alt_hit;
	logic [LETTER_COUNT-1:0] lit;
	logic                    paint;
	logic [COLOR_W-1:0]      sky_r;
	logic [COLOR_W-1:0]      sky_g;

	function automatic logic in_rect(glyph_rect_t rect, coord_t px, coord_t py);
		return (px >= rect.x_lo) && (px <= rect.x_hi) &&
			(py >= rect.y_lo) && (py <= rect.y_hi);
	endfunction

	// Slot k is shown from frame k * LETTER_FRAMES on
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			letter_div <= '0;
			blink_div  <= '0;
			reveal_cnt <= '0;
			cursor_on  <= 1'b0;
		end else if (raster.frame_start) begin
			if (letter_div == LETTER_DIV_W'(LETTER_FRAMES - 1)) begin
				letter_div <= '0;
			end else begin
				letter_div <= letter_div + 1'b1;
			end
			if (letter_div == '0 && reveal_cnt != REVEAL_W'(LETTER_COUNT)) begin
				reveal_cnt <= reveal_cnt + 1'b1;
			end
			if (blink_div == CURSOR_DIV_W'(CURSOR_FRAMES - 1)) begin
				blink_div <= '0;
			end else begin
				blink_div <= blink_div + 1'b1;
			end
			if (blink_div == '0) begin
				cursor_on <= ~cursor_on;
			end
		end
	end

	always_comb begin
		prim_hit = '0;
		alt_hit = '0;
		for (int i = 0; i < GLYPH_RECTS; i++) begin
			if (in_rect(GLYPH_RECT[i], raster.x, raster.y)) begin
				prim_hit[GLYPH_RECT[i].slot] = 1'b1;
			end
		end
		for (int i = 0; i < ALT_RECTS; i++) begin
			if (in_rect(ALT_RECT[i], raster.x, raster.y)) begin
				alt_hit[ALT_RECT[i].slot] = 1'b1;
			end
		end
	end

	always_comb begin
		for (int k = 0; k < LETTER_COUNT; k++) begin
			if (!msg_sel && k >= 1 && k <= ALT_COUNT) begin
				lit[k] = alt_hit[k] && (REVEAL_W'(k) < reveal_cnt);
			end else begin
				lit[k] = prim_hit[k] && (REVEAL_W'(k) < reveal_cnt);
			end
		end
		lit[LETTER_COUNT-1] = lit[LETTER_COUNT-1] && cursor_on;
		paint = |lit;
	end

	// Sky darkens towards the bottom in bands of 128 rows
	assign sky_r = {1'b1, ~&raster.y[8:7]};
	assign sky_g = ~raster.y[8:7];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pixel.hsync <= 1'b1;
			pixel.vsync <= 1'b1;
			pixel.r     <= '0;
			pixel.g     <= '0;
			pixel.b     <= '0;
		end else begin
			pixel.hsync <= raster.hsync;
			pixel.vsync <= raster.vsync;
			if (!raster.active) begin
				pixel.r <= '0;
				pixel.g <= '0;
				pixel.b <= '0;
			end else if (paint) begin
				pixel.r <= '1;
				pixel.g <= '1;
				pixel.b <= '1;
			end else begin
				pixel.r <= sky_r;
				pixel.g <= sky_g;
				pixel.b <= '0;
			end
		end
	end

	a_reveal_max: assert property (@(posedge clk) disable iff (!rst_n)
		reveal_cnt <= REVEAL_W'(LETTER_COUNT));

endmodule

// File: hw/skyking_pkg.sv
package skyking_pkg;

	// 640x480 at 60 Hz, 25 MHz pixel clock
	localparam int H_ACTIVE = 640;
	localparam int H_FRONT = 16;
	localparam int H_SYNC = 96;
	localparam int H_BACK = 48;
	localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;

	localparam int V_ACTIVE = 480;
	localparam int V_FRONT = 10;
	localparam int V_SYNC = 2;
	localparam int V_BACK = 33;
	localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

	localparam int COORD_W = 10;
	localparam int COLOR_W = 2;

	// Text line, cursor is the last slot
	localparam int LETTER_COUNT = 18;
	localparam int ALT_COUNT = 5;
	localparam int LETTER_FRAMES = 2;
	localparam int CURSOR_FRAMES = 8;
	localparam int REVEAL_W = $clog2(LETTER_COUNT + 1);
	localparam int LETTER_DIV_W = $clog2(LETTER_FRAMES);
	localparam int CURSOR_DIV_W = $clog2(CURSOR_FRAMES);
	localparam int GLYPH_RECTS = 68;
	localparam int ALT_RECTS = 20;

	localparam int WAVE_DEPTH = 32;
	localparam int PHASE_W = $clog2(WAVE_DEPTH);
	localparam int X_W = 8;
	localparam int Y_W = 7;
	localparam int Y_MAX = 126;
	localparam int TRIG_BIT = 3;

	typedef logic [COORD_W-1:0] coord_t;

	typedef enum logic [1:0] {
		MODE_VGA   = 2'd0,
		MODE_XY1   = 2'd1,
		MODE_VGA_X = 2'd2,
		MODE_XY2   = 2'd3
	} pin_mode_t;

	typedef struct packed {
		logic               hsync;
		logic               vsync;
		logic [COLOR_W-1:0] r;
		logic [COLOR_W-1:0] g;
		logic [COLOR_W-1:0] b;
	} vga_pixel_t;

	typedef struct packed {
		logic [X_W-1:0] x;
		logic [Y_W-1:0] y;
		logic           trig;
	} scope_sample_t;

	typedef struct packed {
		coord_t x;
		coord_t y;
		logic   active;
		logic   hsync;
		logic   vsync;
		logic   frame_start;
	} raster_t;

	// Inclusive pixel box owned by one text slot
	typedef struct packed {
		logic [REVEAL_W-1:0] slot;
		coord_t              x_lo;
		coord_t              x_hi;
		coord_t              y_lo;
		coord_t              y_hi;
	} glyph_rect_t;

endpackage

// File: hw/skyking_top.sv
`timescale 1ns/1ps

module skyking_top import skyking_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  logic [7:0] ui_in,
	output logic [7:0] uo_out,
	output logic [7:0] uio_out,
	output logic [7:0] uio_oe
);

	raster_t       raster;
	vga_pixel_t    pixel;
	scope_sample_t sample;

	// Bidirectional pins are outputs only
	assign uio_oe = 8'hff;

	vga_timing vga_timing_i (
		.clk    (clk),
		.rst_n  (rst_n),
		.raster (raster)
	);

	sky_scene sky_scene_i (
		.clk     (clk),
		.rst_n   (rst_n),
		.raster  (raster),
		.msg_sel (ui_in[3]),
		.pixel   (pixel)
	);

	scope_wave scope_wave_i (
		.clk    (clk),
		.rst_n  (rst_n),
		.sample (sample)
	);

	pmod_mux pmod_mux_i (
		.mode    (pin_mode_t'(ui_in[1:0])),
		.pixel   (pixel),
		.sample  (sample),
		.uo_out  (uo_out),
		.uio_out (uio_out)
	);

endmodule

// File: hw/vga_timing.sv
`timescale 1ns/1ps

module vga_timing import skyking_pkg::*; (
	input  logic    clk,
	input  logic    rst_n,
	output raster_t raster
);

	coord_t h_cnt;
	coord_t v_cnt;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			h_cnt <= '0;
			v_cnt <= '0;
		end else if (h_cnt == COORD_W'(H_TOTAL - 1)) begin
			h_cnt <= '0;
			if (v_cnt == COORD_W'(V_TOTAL - 1)) begin
				v_cnt <= '0;
			end else begin
				v_cnt <= v_cnt + 1'b1;
			end
		end else begin
			h_cnt <= h_cnt + 1'b1;
		end
	end

	// Both syncs are active low
	always_comb begin
		raster.x = h_cnt;
		raster.y = v_cnt;
		raster.active = (h_cnt < COORD_W'(H_ACTIVE)) && (v_cnt < COORD_W'(V_ACTIVE));
		raster.hsync = !((h_cnt >= COORD_W'(H_ACTIVE + H_FRONT)) &&
			(h_cnt < COORD_W'(H_ACTIVE + H_FRONT + H_SYNC)));
		raster.vsync = !((v_cnt >= COORD_W'(V_ACTIVE + V_FRONT)) &&
			(v_cnt < COORD_W'(V_ACTIVE + V_FRONT + V_SYNC)));
		raster.frame_start = (h_cnt == '0) && (v_cnt == '0);
	end

	a_h_range: assert property (@(posedge clk) disable iff (!rst_n)
		h_cnt < COORD_W'(H_TOTAL));

endmodule

// File: include/scope_wave.svh
// Closed curve for the X/Y scope with one entry per clock
localparam logic [X_W-1:0] WAVE_X [WAVE_DEPTH] = '{
	8'd186, 8'd207, 8'd225, 8'd239,
	8'd249, 8'd254, 8'd254, 8'd249,
	8'd240, 8'd226, 8'd209, 8'd188,
	8'd165, 8'd140, 8'd115, 8'd91,
	8'd68, 8'd47, 8'd29, 8'd15,
	8'd5, 8'd0, 8'd0, 8'd5,
	8'd14, 8'd28, 8'd46, 8'd67,
	8'd90, 8'd114, 8'd139, 8'd164
};

// Y runs about a quarter turn ahead of X
localparam logic [Y_W-1:0] WAVE_Y [WAVE_DEPTH] = '{
	7'd120, 7'd113, 7'd104, 7'd94,
	7'd83, 7'd71, 7'd58, 7'd46,
	7'd34, 7'd24, 7'd15, 7'd7,
	7'd3, 7'd0, 7'd0, 7'd2,
	7'd7, 7'd13, 7'd22, 7'd33,
	7'd44, 7'd56, 7'd69, 7'd81,
	7'd93, 7'd103, 7'd112, 7'd119,
	7'd124, 7'd126, 7'd126, 7'd124
};

// File: include/skyking_glyphs.svh
// SEE YOU
localparam glyph_rect_t GLYPH_RECT [GLYPH_RECTS] = '{
	'{5'd0, 10'd0, 10'd15, 10'd416, 10'd419},
	'{5'd0, 10'd0, 10'd3, 10'd416, 10'd423},
	'{5'd0, 10'd0, 10'd15, 10'd424, 10'd427},
	'{5'd0, 10'd12, 10'd15, 10'd424, 10'd431},
	'{5'd0, 10'd0, 10'd15, 10'd432, 10'd435},
	'{5'd1, 10'd24, 10'd39, 10'd416, 10'd419},
	'{5'd1, 10'd24, 10'd39, 10'd424, 10'd427},
	'{5'd1, 10'd24, 10'd39, 10'd432, 10'd435},
	'{5'd1, 10'd24, 10'd27, 10'd416, 10'd431},
	'{5'd2, 10'd48, 10'd63, 10'd416, 10'd419},
	'{5'd2, 10'd48, 10'd63, 10'd424, 10'd427},
	'{5'd2, 10'd48, 10'd63, 10'd432, 10'd435},
	'{5'd2, 10'd48, 10'd51, 10'd416, 10'd431},
	'{5'd3, 10'd88, 10'd91, 10'd416, 10'd423},
	'{5'd3, 10'd100, 10'd103, 10'd416, 10'd423},
	'{5'd3, 10'd88, 10'd103, 10'd424, 10'd427},
	'{5'd3, 10'd92, 10'd99, 10'd424, 10'd435},
	'{5'd4, 10'd112, 10'd127, 10'd416, 10'd419},
	'{5'd4, 10'd112, 10'd127, 10'd432, 10'd435},
	'{5'd4, 10'd112, 10'd115, 10'd416, 10'd431},
	'{5'd4, 10'd124, 10'd127, 10'd416, 10'd431},
	'{5'd5, 10'd136, 10'd151, 10'd432, 10'd435},
	'{5'd5, 10'd136, 10'd139, 10'd416, 10'd431},
	'{5'd5, 10'd148, 10'd151, 10'd416, 10'd431},
	// SPACE
	'{5'd6, 10'd176, 10'd191, 10'd416, 10'd419},
	'{5'd6, 10'd176, 10'd179, 10'd416, 10'd423},
	'{5'd6, 10'd176, 10'd191, 10'd424, 10'd427},
	'{5'd6, 10'd188, 10'd191, 10'd424, 10'd431},
	'{5'd6, 10'd176, 10'd191, 10'd432, 10'd435},
	'{5'd7, 10'd200, 10'd203, 10'd416, 10'd435},
	'{5'd7, 10'd212, 10'd215, 10'd416, 10'd423},
	'{5'd7, 10'd200, 10'd215, 10'd416, 10'd419},
	'{5'd7, 10'd200, 10'd215, 10'd424, 10'd427},
	'{5'd8, 10'd224, 10'd239, 10'd416, 10'd419},
	'{5'd8, 10'd224, 10'd239, 10'd424, 10'd427},
	'{5'd8, 10'd224, 10'd227, 10'd416, 10'd435},
	'{5'd8, 10'd236, 10'd239, 10'd416, 10'd435},
	'{5'd9, 10'd248, 10'd251, 10'd416, 10'd431},
	'{5'd9, 10'd248, 10'd263, 10'd416, 10'd419},
	'{5'd9, 10'd248, 10'd263, 10'd432, 10'd435},
	'{5'd10, 10'd272, 10'd287, 10'd416, 10'd419},
	'{5'd10, 10'd272, 10'd287, 10'd424, 10'd427},
	'{5'd10, 10'd272, 10'd287, 10'd432, 10'd435},
	'{5'd10, 10'd272, 10'd275, 10'd416, 10'd431},
	// COWBOY
	'{5'd11, 10'd312, 10'd315, 10'd416, 10'd431},
	'{5'd11, 10'd312, 10'd327, 10'd416, 10'd419},
	'{5'd11, 10'd312, 10'd327, 10'd432, 10'd435},
	'{5'd12, 10'd336, 10'd351, 10'd416, 10'd419},
	'{5'd12, 10'd336, 10'd351, 10'd432, 10'd435},
	'{5'd12, 10'd336, 10'd339, 10'd416, 10'd431},
	'{5'd12, 10'd348, 10'd351, 10'd416, 10'd431},
	'{5'd13, 10'd360, 10'd375, 10'd424, 10'd431},
	'{5'd13, 10'd360, 10'd363, 10'd416, 10'd435},
	'{5'd13, 10'd372, 10'd375, 10'd416, 10'd435},
	'{5'd14, 10'd384, 10'd399, 10'd416, 10'd419},
	'{5'd14, 10'd384, 10'd399, 10'd424, 10'd427},
	'{5'd14, 10'd384, 10'd399, 10'd432, 10'd435},
	'{5'd14, 10'd384, 10'd387, 10'd416, 10'd431},
	'{5'd14, 10'd396, 10'd399, 10'd416, 10'd431},
	'{5'd15, 10'd408, 10'd423, 10'd416, 10'd419},
	'{5'd15, 10'd408, 10'd423, 10'd432, 10'd435},
	'{5'd15, 10'd408, 10'd411, 10'd416, 10'd431},
	'{5'd15, 10'd420, 10'd423, 10'd416, 10'd431},
	'{5'd16, 10'd432, 10'd435, 10'd416, 10'd423},
	'{5'd16, 10'd444, 10'd447, 10'd416, 10'd423},
	'{5'd16, 10'd432, 10'd447, 10'd424, 10'd427},
	'{5'd16, 10'd436, 10'd443, 10'd424, 10'd435},
	// Underscore cursor
	'{5'd17, 10'd456, 10'd471, 10'd432, 10'd435}
};

// Replaces slots 1 to 5 so the line reads SO LONG
localparam glyph_rect_t ALT_RECT [ALT_RECTS] = '{
	'{5'd1, 10'd24, 10'd39, 10'd416, 10'd419},
	'{5'd1, 10'd24, 10'd39, 10'd432, 10'd435},
	'{5'd1, 10'd24, 10'd27, 10'd416, 10'd431},
	'{5'd1, 10'd36, 10'd39, 10'd416, 10'd431},
	'{5'd2, 10'd64, 10'd67, 10'd416, 10'd431},
	'{5'd2, 10'd64, 10'd79, 10'd432, 10'd435},
	'{5'd3, 10'd88, 10'd103, 10'd416, 10'd419},
	'{5'd3, 10'd88, 10'd103, 10'd432, 10'd435},
	'{5'd3, 10'd88, 10'd91, 10'd416, 10'd431},
	'{5'd3, 10'd100, 10'd103, 10'd416, 10'd431},
	'{5'd4, 10'd112, 10'd115, 10'd416, 10'd435},
	'{5'd4, 10'd124, 10'd127, 10'd416, 10'd435},
	'{5'd4, 10'd112, 10'd127, 10'd424, 10'd427},
	'{5'd4, 10'd112, 10'd119, 10'd420, 10'd423},
	'{5'd4, 10'd120, 10'd127, 10'd428, 10'd431},
	'{5'd5, 10'd136, 10'd139, 10'd416, 10'd431},
	'{5'd5, 10'd148, 10'd151, 10'd424, 10'd431},
	'{5'd5, 10'd136, 10'd151, 10'd416, 10'd419},
	'{5'd5, 10'd144, 10'd151, 10'd424, 10'd427},
	'{5'd5, 10'd136, 10'd151, 10'd432, 10'd435}
};

// File: run.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
	-f skyking.f --top-module tb_skyking -o tb_skyking

# A failing run still has to reach the log search below
./obj_dir/tb_skyking > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "TB FAILED" "$LOG"; then
	echo "Simulation reported a failure"
	exit 1
fi
if ! grep -q "TB PASSED" "$LOG"; then
	echo "Simulation ended without a result"
	exit 1
fi

// File: skyking.f
+incdir+include
+incdir+test
hw/skyking_pkg.sv
hw/vga_timing.sv
hw/sky_scene.sv
hw/scope_wave.sv
hw/pmod_mux.sv
hw/skyking_top.sv
test/tb_skyking.sv

// File: test/tb_tasks.svh
// VGA pins carry the low colour bits in the upper nibble
function automatic logic [3*COLOR_W-1:0] vga_rgb(input logic [7:0] pins);
	return {pins[0], pins[4], pins[1], pins[5], pins[2], pins[6]};
endfunction

function automatic scope_sample_t decode_xy2(input logic [7:0] y_pins,
	input logic [7:0] x_pins);
	scope_sample_t s;
	s.trig = y_pins[7];
	s.y = {y_pins[3], y_pins[6], y_pins[2], y_pins[5], y_pins[1], y_pins[4], y_pins[0]};
	s.x = {x_pins[7], x_pins[3], x_pins[6], x_pins[2], x_pins[5], x_pins[1], x_pins[4],
		x_pins[0]};
	return s;
endfunction

// Table entry currently on the pins
function automatic logic [PHASE_W-1:0] shown_index();
	return PHASE_W'(run_cycles - 1);
endfunction

task automatic wait_phase(input logic [PHASE_W-1:0] k);
	while (shown_index() != k) begin
		@(negedge clk);
	end
endtask

task automatic wait_pin(input int bit_sel, input logic level);
	while (uo_out[bit_sel] != level) begin
		@(negedge clk);
	end
endtask

task automatic wait_pixel(input int frame, input int x, input int y);
	int target;
	while (vs_falls < frame) begin
		@(negedge clk);
	end
	target = last_vs_fall + VS_TO_ORIGIN + y * H_TOTAL + x;
	assert (vs_falls == frame && run_cycles <= target) else
		fail_check($sformatf("pixel (%0d,%0d) of frame %0d was already passed",
			x, y, frame));
	while (run_cycles < target) begin
		@(negedge clk);
	end
endtask

task automatic check_pixel(input int frame, input int x, input int y,
	input logic [COLOR_W-1:0] er, input logic [COLOR_W-1:0] eg,
	input logic [COLOR_W-1:0] eb, input string what);
	logic [3*COLOR_W-1:0] rgb;
	wait_pixel(frame, x, y);
	rgb = vga_rgb(uo_out);
	assert (rgb == {er, eg, eb}) else
		fail_check($sformatf("%s: (%0d,%0d) frame %0d rgb %0d%0d%0d, expected %0d%0d%0d",
			what, x, y, frame, rgb[5:4], rgb[3:2], rgb[1:0], er, eg, eb));
endtask

// Bands of 128 rows with red dropping only in the last band
task automatic check_sky(input int frame, input int x, input int y, input string what);
	int band;
	band = (y >> 7) & 3;
	check_pixel(frame, x, y, (band < 3) ? 2'd3 : 2'd2, COLOR_W'(3 - band), 2'd0, what);
endtask

task automatic test_gradient_top();
	check_pixel(0, 100, 100, 2'd3, 2'd3, 2'd0, "top sky");
	check_pixel(0, 700, 100, 2'd0, 2'd0, 2'd0, "horizontal blanking");
endtask

task automatic test_reveal_first();
	check_pixel(0, 8, 417, 2'd3, 2'd3, 2'd3, "letter 0 shown");
	check_sky(0, 28, 417, "letter 1 hidden");
endtask

task automatic test_gradient_bottom();
	check_pixel(0, 100, 417, 2'd2, 2'd0, 2'd0, "bottom sky");
endtask

task automatic test_sync_timing();
	int t_fall;
	int low_len;
	int period;
	wait_pin(7, 1'b1);
	wait_pin(7, 1'b0);
	t_fall = run_cycles;
	wait_pin(7, 1'b1);
	low_len = run_cycles - t_fall;
	wait_pin(7, 1'b0);
	period = run_cycles - t_fall;
	assert (low_len == 96 && period == 800) else
		fail_check($sformatf("hsync low %0d of %0d cycles, expected 96 of 800",
			low_len, period));
	wait_pin(3, 1'b1);
	wait_pin(3, 1'b0);
	t_fall = run_cycles;
	wait_pin(3, 1'b1);
	low_len = run_cycles - t_fall;
	assert (low_len == 1600) else
		fail_check($sformatf("vsync low for %0d cycles, expected 1600", low_len));
endtask

task automatic test_reveal_next();
	check_pixel(2, 28, 417, 2'd3, 2'd3, 2'd3, "letter 1 revealed");
endtask

task automatic test_alt_message();
	check_pixel(3, 32, 425, 2'd3, 2'd3, 2'd3, "E middle bar");
	ui_in[3] = 1'b0;
	check_sky(4, 32, 425, "alternate O inside");
	ui_in[3] = 1'b1;
endtask

task automatic test_scope_xy2();
	logic [PHASE_W-1:0] idx;
	scope_sample_t      s;
	logic               exp_trig;
	ui_in[1:0] = MODE_XY2;
	idx = PHASE_W'($random(seed));
	@(negedge clk);
	wait_phase(idx);
	repeat (2 * WAVE_DEPTH) begin
		// Trig is high on every second group of eight entries
		exp_trig = ((int'(idx) / 8) % 2) == 1;
		s = decode_xy2(uo_out, uio_out);
		assert (s.x == WAVE_X[idx] && s.y == WAVE_Y[idx] && s.trig == exp_trig) else
			fail_check($sformatf("entry %0d x/y/trig %0d/%0d/%0d, expected %0d/%0d/%0d",
				idx, s.x, s.y, s.trig, WAVE_X[idx], WAVE_Y[idx], exp_trig));
		assert (uio_oe == 8'hff) else
			fail_check($sformatf("uio_oe is %02h, expected ff", uio_oe));
		idx++;
		@(negedge clk);
	end
endtask

task automatic test_pin_modes();
	logic [PHASE_W-1:0] k;
	scope_sample_t      s;
	logic [7:0]         xy1_expected;
	ui_in[1:0] = MODE_VGA;
	@(negedge clk);
	assert (uio_out == 8'h00 && uio_oe == 8'hff) else
		fail_check($sformatf("VGA mode uio_out %02h uio_oe %02h", uio_out, uio_oe));
	ui_in[1:0] = MODE_VGA_X;
	@(negedge clk);
	s = decode_xy2(8'h00, uio_out);
	assert (s.x == WAVE_X[shown_index()]) else
		fail_check($sformatf("VGA_X mode x%0d, expected x%0d",
			s.x, WAVE_X[shown_index()]));
	// Capture one entry in XY2 and revisit it in XY1
	ui_in[1:0] = MODE_XY2;
	k = PHASE_W'($random(seed));
	@(negedge clk);
	wait_phase(k);
	s = decode_xy2(uo_out, uio_out);
	ui_in[1:0] = MODE_XY1;
	@(negedge clk);
	wait_phase(k);
	xy1_expected = {s.x[4], s.x[6], s.y[4], s.y[6], s.x[5], s.x[7], s.y[5], s.trig};
	assert (uo_out == xy1_expected && uio_out == 8'h00 && uio_oe == 8'hff) else
		fail_check($sformatf("XY1 entry %0d gives %02h/%02h, expected %02h/00",
			k, uo_out, uio_out, xy1_expected));
	ui_in[1:0] = MODE_VGA;
endtask

// File: test/tb_skyking.sv
`timescale 1ns/1ps

module tb_skyking import skyking_pkg::*; ();

	localparam int CYCLE_LIMIT = 3_000_000;
	// From a vsync fall on the pins to pixel (0,0) of the next frame
	localparam int VS_TO_ORIGIN = (V_TOTAL - V_ACTIVE - V_FRONT) * H_TOTAL;

	`include "scope_wave.svh"

	logic       clk;
	logic       rst_n;
	logic [7:0] ui_in;
	logic [7:0] uo_out;
	logic [7:0] uio_out;
	logic [7:0] uio_oe;

	int   seed = 32'h4a28_0059;
	int   cycle_count = 0;
	int   run_cycles;
	int   vs_falls;
	int   last_vs_fall;
	logic vs_prev;
	logic vga_mode;

	skyking_top dut_i (
		.clk     (clk),
		.rst_n   (rst_n),
		.ui_in   (ui_in),
		.uo_out  (uo_out),
		.uio_out (uio_out),
		.uio_oe  (uio_oe)
	);

	always #10 clk = ~clk;

	// Clock edges since reset release
	always @(posedge clk) begin
		if (!rst_n) begin
			run_cycles <= 0;
		end else begin
			run_cycles <= run_cycles + 1;
		end
	end

	assign vga_mode = (ui_in[1:0] == MODE_VGA) || (ui_in[1:0] == MODE_VGA_X);

	// Tracks vsync falls on the pins, frame 0 anchored at reset release
	always @(posedge clk) begin
		if (!rst_n) begin
			vs_prev      <= 1'b1;
			vs_falls     <= 0;
			last_vs_fall <= 1 - VS_TO_ORIGIN;
		end else if (vga_mode) begin
			vs_prev <= uo_out[3];
			if (vs_prev && !uo_out[3]) begin
				vs_falls     <= vs_falls + 1;
				last_vs_fall <= run_cycles;
			end
		end else begin
			vs_prev <= 1'b1;
		end
	end

	task automatic abort_run();
		$display("TB FAILED");
		$fatal(1, "Run stopped on the first failure");
	endtask

	task automatic fail_check(input string msg);
		$display("Error at %0t ns: %s", $time, msg);
		abort_run();
	endtask

	`include "tb_tasks.svh"

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count == CYCLE_LIMIT) begin
			$display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
			abort_run();
		end
	end

	initial begin
		clk   = 1'b0;
		rst_n = 1'b0;
		// VGA pins, primary text
		ui_in = 8'h08;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		test_gradient_top();
		test_reveal_first();
		test_gradient_bottom();
		test_sync_timing();
		test_reveal_next();
		test_alt_message();
		test_scope_xy2();
		test_pin_modes();

		$display("TB PASSED");
		$finish;
	end

endmodule
